/* vlog.f */
siggen_pkg.sv
siggen_setting_regs.sv
siggen_sine_source.sv
siggen_fifo.sv
siggen_source_select.sv
siggen_packetizer.sv
siggen_top.sv
tb_siggen_sva.sv
tb_siggen.sv

/* tb_siggen.sv */
/* Randomized testbench for siggen_top with a model of the sample stream.
   Waveform, frequency and amplitude change only with enable low and no packet open. */

`default_nettype none

module tb_siggen;
  timeunit 1ns;
  timeprecision 1ps;
  import siggen_pkg::*;

  localparam logic [31:0] SEED          = 32'h0945_2725;
  localparam int          CONST_ROUNDS  = 4;
  localparam int          CONST_WORDS   = 100;
  localparam int          SINE_ROUNDS   = 5;
  localparam int          SINE_WORDS    = 120;
  localparam int          SIZE_ROUNDS   = 6;
  localparam int          WRAP_PACKETS  = 4200;
  localparam int          STARVE_ROUNDS = 8;
  localparam int          STARVE_WORDS  = 150;
  localparam int          TAIL_WORDS    = 40;
  localparam int          IDLE_CYCLES   = 300;
  localparam int          QUIET_CYCLES  = 32;
  localparam int          PKT64_WORDS   = 33;
  localparam int          MAX_PKT_WORDS = SIGGEN_MAX_PKT_SAMPLES / 2 + 1;
  // Every run may finish one more packet than its target
  localparam int EXP_WORDS = CONST_ROUNDS * (CONST_WORDS + PKT64_WORDS) +
                             SINE_ROUNDS * (SINE_WORDS + PKT64_WORDS) +
                             SIZE_ROUNDS * 3 * MAX_PKT_WORDS + 2 * WRAP_PACKETS + 2 +
                             STARVE_ROUNDS * (STARVE_WORDS + PKT64_WORDS) +
                             TAIL_WORDS + PKT64_WORDS;
  localparam int WATCHDOG_CYCLES = 40 * EXP_WORDS + 10000;

  logic      ce_clk;
  logic      arst_n;
  set_bus_t  set_bus;
  out_word_t word;
  logic      word_valid;
  logic      credit;

  // Model state
  out_word_t   exp_q[$];
  bit          exp_hdr_q[$];
  logic [31:0] mdl_freq;
  sample_t     mdl_amp;
  logic [2:0]  mdl_wave;
  logic [9:0]  mdl_pkt;
  logic [15:0] mdl_src;
  logic [15:0] mdl_dst;
  logic [11:0] mdl_seq;
  logic [31:0] mdl_phase;
  int          mdl_left;

  int words_seen      = 0;
  int packets_seen    = 0;
  int quiet_cycles    = 0;
  int pending_credits = 0;
  int rate_pct        = 100;
  int rate_cycles     = 0;
  int checks          = 0;
  int errors          = 0;
  bit full_rate       = 1'b0;

  initial begin
    ce_clk = 1'b0;
    forever #5 ce_clk = ~ce_clk;
  end

  siggen_top siggen_top_i (
    .i_ce_clk     (ce_clk),
    .i_arst_n     (arst_n),
    .i_set        (set_bus),
    .o_word       (word),
    .o_word_valid (word_valid),
    .i_credit     (credit)
  );

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s sample got (%0d,%0d) expected (%0d,%0d)",
               $time, what, got.i, got.q, exp.i, exp.q);
    end
  endtask

  task automatic check_word(input out_word_t got, input out_word_t exp);
    checks++;
    if (got.last !== exp.last) begin
      errors++;
      $display("CHECK FAILED at %0t: last flag got %0b expected %0b",
               $time, got.last, exp.last);
    end
    check_sample(sample_t'(got.data[63:32]), sample_t'(exp.data[63:32]), "first");
    check_sample(sample_t'(got.data[31:0]), sample_t'(exp.data[31:0]), "second");
  endtask

  task automatic check_header(input chdr_hdr_t got, input chdr_hdr_t exp, input logic got_last);
    checks++;
    if (got !== exp || got_last !== 1'b0) begin
      errors++;
      $display("CHECK FAILED at %0t: header got %h last %0b, expected seq %0d len %0d sid %h>%h",
               $time, got, got_last, exp.seqnum, exp.length, exp.src_sid, exp.dst_sid);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  task automatic model_sample(output sample_t s);
    if (mdl_wave == SIGGEN_WAVE_CONST) begin
      s = mdl_amp;
    end else if (mdl_wave == SIGGEN_WAVE_SINE) begin
      s = sine_entry(mdl_phase[31 -: SIGGEN_TABLE_BITS]);
      mdl_phase = mdl_phase + mdl_freq;
    end else begin
      errors++;
      s = '0;
      $display("Sample word seen at %0t while waveform %0d selects no source", $time, mdl_wave);
    end
  endtask

  // Next expected word is a header when no packet is open
  task automatic model_word();
    chdr_hdr_t hdr;
    out_word_t w;
    sample_t   s0;
    sample_t   s1;
    if (mdl_left == 0) begin
      hdr.pkt_type = 2'b00;
      hdr.has_time = 1'b0;
      hdr.eob      = 1'b0;
      hdr.seqnum   = mdl_seq;
      hdr.length   = 16'(8 * (1 + mdl_pkt / 2));
      hdr.src_sid  = mdl_src;
      hdr.dst_sid  = mdl_dst;
      w.data       = hdr;
      w.last       = 1'b0;
      exp_hdr_q.push_back(1'b1);
      mdl_seq      = mdl_seq + 1'b1;
      mdl_left     = mdl_pkt;
    end else begin
      model_sample(s0);
      model_sample(s1);
      mdl_left = mdl_left - 2;
      w.data   = {s0, s1};
      w.last   = (mdl_left == 0);
      exp_hdr_q.push_back(1'b0);
    end
    exp_q.push_back(w);
  endtask

  always @(posedge ce_clk) begin : monitor
    out_word_t exp;
    bit        is_hdr;
    if (word_valid === 1'b1) begin
      quiet_cycles = 0;
      words_seen++;
      pending_credits++;
      if (exp_q.size() == 0) begin
        model_word();
      end
      exp    = exp_q.pop_front();
      is_hdr = exp_hdr_q.pop_front();
      if (is_hdr) begin
        packets_seen++;
        check_header(chdr_hdr_t'(word.data), chdr_hdr_t'(exp.data), word.last);
      end else begin
        check_word(word, exp);
      end
    end else begin
      quiet_cycles++;
    end
  end

  // Consumer returns one credit per word at a rate that changes in segments
  task automatic return_credits();
    forever begin
      @(posedge ce_clk);
      #1;
      if (rate_cycles == 0) begin
        rate_pct    = ($urandom_range(7) == 0) ? 0 : $urandom_range(100, 5);
        rate_cycles = $urandom_range(300, 20);
      end
      rate_cycles--;
      if (pending_credits > 0 && (full_rate || $urandom_range(99) < rate_pct)) begin
        credit = 1'b1;
        pending_credits--;
      end else begin
        credit = 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  task automatic next_cycle();
    @(posedge ce_clk);
    #1;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    set_bus.stb  = 1'b1;
    set_bus.addr = addr;
    set_bus.data = data;
    next_cycle();
    set_bus.stb  = 1'b0;
    case (addr)
      SIGGEN_SR_FREQ:      mdl_freq = data;
      SIGGEN_SR_AMPLITUDE: mdl_amp  = sample_t'(data);
      SIGGEN_SR_WAVEFORM:  mdl_wave = data[2:0];
      SIGGEN_SR_SID: begin
        mdl_src = data[31:16];
        mdl_dst = data[15:0];
      end
      SIGGEN_SR_PKT_SIZE: begin
        // Odd, zero and oversize values leave the size alone
        if (data[0] == 1'b0 && data != 0 && data <= SIGGEN_MAX_PKT_SAMPLES) begin
          mdl_pkt = data[9:0];
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic wait_quiet();
    quiet_cycles = 0;
    while (quiet_cycles < QUIET_CYCLES) begin
      next_cycle();
    end
  endtask

  // Drain and top up the open packet with short enable windows
  task automatic settle();
    int k;
    write_reg(SIGGEN_SR_ENABLE, 32'd0);
    full_rate = 1'b1;
    wait_quiet();
    while (mdl_left != 0) begin
      k = (mdl_left > 1) ? mdl_left - 1 : 1;
      write_reg(SIGGEN_SR_ENABLE, 32'd1);
      repeat (k - 1) next_cycle();
      write_reg(SIGGEN_SR_ENABLE, 32'd0);
      wait_quiet();
    end
    full_rate = 1'b0;
  endtask

  task automatic run_words(input int n, input bit toggle);
    int target;
    target = words_seen + n;
    write_reg(SIGGEN_SR_ENABLE, 32'd1);
    while (words_seen < target) begin
      repeat ($urandom_range(60, 1)) next_cycle();
      if (toggle) begin
        write_reg(SIGGEN_SR_ENABLE, 32'd0);
        repeat ($urandom_range(60, 1)) next_cycle();
        write_reg(SIGGEN_SR_ENABLE, 32'd1);
      end
    end
    settle();
  endtask

  task automatic report_counts();
    $display("Checks %0d, errors %0d, assertion failures %0d, words %0d, packets %0d",
             checks, errors, siggen_top_i.siggen_sva_i.assert_fails, words_seen, packets_seen);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge ce_clk);
    $display("Run timed out after %0d cycles, %0d words seen", WATCHDOG_CYCLES, words_seen);
    report_counts();
    $display("Regression failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin : main
    int          pkt;
    logic [31:0] bad;
    void'($urandom(SEED));
    arst_n    = 1'b0;
    set_bus   = '0;
    credit    = 1'b0;
    mdl_freq  = '0;
    mdl_amp   = '0;
    mdl_wave  = '0;
    mdl_pkt   = 10'd64;
    mdl_src   = '0;
    mdl_dst   = '0;
    mdl_seq   = '0;
    mdl_phase = '0;
    mdl_left  = 0;
    fork
      return_credits();
    join_none
    repeat (8) @(posedge ce_clk);
    #1;
    arst_n = 1'b1;
    next_cycle();

    // Constant source with random amplitude and SIDs
    write_reg(SIGGEN_SR_WAVEFORM, 32'(SIGGEN_WAVE_CONST));
    for (int r = 0; r < CONST_ROUNDS; r++) begin
      write_reg(SIGGEN_SR_AMPLITUDE, $urandom());
      write_reg(SIGGEN_SR_SID, $urandom());
      run_words(CONST_WORDS, 1'b0);
    end

    // Sine source with frequency 0 first
    write_reg(SIGGEN_SR_WAVEFORM, 32'(SIGGEN_WAVE_SINE));
    for (int r = 0; r < SINE_ROUNDS; r++) begin
      write_reg(SIGGEN_SR_FREQ, (r == 0) ? 32'd0 : (r == 1) ? 32'h0100_0000 : $urandom());
      run_words(SINE_WORDS, 1'b0);
    end

    // Each valid packet size write is followed by one that must be dropped
    for (int r = 0; r < SIZE_ROUNDS; r++) begin
      pkt = (r == SIZE_ROUNDS - 1) ? SIGGEN_MAX_PKT_SAMPLES : 2 * $urandom_range(32, 1);
      case (r % 4)
        0:       bad = pkt + 1;
        1:       bad = 32'd0;
        2:       bad = 32'd514;
        default: bad = 32'h0001_0002;
      endcase
      write_reg(SIGGEN_SR_PKT_SIZE, pkt);
      write_reg(SIGGEN_SR_PKT_SIZE, bad);
      write_reg(SIGGEN_SR_WAVEFORM, r % 2);
      run_words(2 * (pkt / 2 + 1), 1'b0);
    end

    // Small packets to wrap the sequence number
    write_reg(SIGGEN_SR_PKT_SIZE, 32'd2);
    write_reg(SIGGEN_SR_WAVEFORM, 32'(SIGGEN_WAVE_CONST));
    run_words(2 * WRAP_PACKETS, 1'b0);

    // Credit starvation with enable dropped mid-packet
    write_reg(SIGGEN_SR_PKT_SIZE, 32'd64);
    for (int r = 0; r < STARVE_ROUNDS; r++) begin
      write_reg(SIGGEN_SR_WAVEFORM, r % 2);
      write_reg(SIGGEN_SR_AMPLITUDE, $urandom());
      write_reg(SIGGEN_SR_FREQ, $urandom());
      run_words(STARVE_WORDS, 1'b1);
    end

    // Waveform code 3 gives nothing and the sine then picks up where it stopped
    pkt = words_seen;
    write_reg(SIGGEN_SR_WAVEFORM, 32'd3);
    write_reg(SIGGEN_SR_ENABLE, 32'd1);
    repeat (IDLE_CYCLES) next_cycle();
    write_reg(SIGGEN_SR_ENABLE, 32'd0);
    wait_quiet();
    if (words_seen != pkt) begin
      errors++;
      $display("Output words appeared while waveform code 3 was selected");
    end
    write_reg(SIGGEN_SR_WAVEFORM, 32'(SIGGEN_WAVE_SINE));
    run_words(TAIL_WORDS, 1'b0);

    report_counts();
    if (errors == 0 && siggen_top_i.siggen_sva_i.assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_siggen_sva.sv */
/* Assertions on output credits and packet framing for siggen_top.
   The header test looks only at the fixed header fields and the length range. */

`default_nettype none

module tb_siggen_sva (
  input logic                                   i_ce_clk,
  input logic                                   i_arst_n,
  input logic [siggen_pkg::SIGGEN_CREDIT_W-1:0] i_credit_cnt,
  input logic                                   i_credit,
  input logic                                   i_word_valid,
  input siggen_pkg::out_word_t                  i_word
);
  timeunit 1ns;
  timeprecision 1ps;
  import siggen_pkg::*;

  chdr_hdr_t hdr;
  logic      hdr_shape;
  logic      after_last_q;
  int        outstanding_q;
  int        assert_fails = 0;

  assign hdr       = chdr_hdr_t'(i_word.data);
  assign hdr_shape = (hdr.pkt_type == 2'b00) && !hdr.has_time && !hdr.eob &&
                     (hdr.length[2:0] == 3'd0) && (hdr.length >= 16'd16) &&
                     (hdr.length <= 16'(8 * (1 + SIGGEN_MAX_PKT_SAMPLES / 2))) &&
                     !i_word.last;

  // First word after reset opens a packet
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      after_last_q <= 1'b1;
    end else if (i_word_valid) begin
      after_last_q <= i_word.last;
    end
  end

  // Words sent and not yet paid back by a credit
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      outstanding_q <= 0;
    end else if (i_word_valid && !i_credit) begin
      outstanding_q <= outstanding_q + 1;
    end else if (!i_word_valid && i_credit && (outstanding_q > 0)) begin
      outstanding_q <= outstanding_q - 1;
    end
  end

  a_credit_count: assert property (@(posedge i_ce_clk) disable iff (!i_arst_n)
    (int'(i_credit_cnt) + outstanding_q) == int'(SIGGEN_CREDITS))
    else begin
      assert_fails++;
      $error("Credit count does not match words sent and credits returned");
    end

  a_no_credit_send: assert property (@(posedge i_ce_clk) disable iff (!i_arst_n)
    i_word_valid |-> (outstanding_q < int'(SIGGEN_CREDITS)))
    else begin
      assert_fails++;
      $error("Output word sent with no credit left");
    end

  a_hdr_after_last: assert property (@(posedge i_ce_clk) disable iff (!i_arst_n)
    (i_word_valid && after_last_q) |-> hdr_shape)
    else begin
      assert_fails++;
      $error("Word after a last word is not a header");
    end

endmodule

bind siggen_top tb_siggen_sva siggen_sva_i (
  .i_ce_clk     (i_ce_clk),
  .i_arst_n     (i_arst_n),
  .i_credit_cnt (credit_cnt),
  .i_credit     (i_credit),
  .i_word_valid (o_word_valid),
  .i_word       (o_word)
);

`default_nettype wire

/* siggen_top.sv */
/* Signal generator top with credit-based output, one credit per word taken.
   The consumer must take every o_word_valid word, there is no output ready. */

`default_nettype none

module siggen_top (
  input  logic                  i_ce_clk,
  input  logic                  i_arst_n,
  input  siggen_pkg::set_bus_t  i_set,
  output siggen_pkg::out_word_t o_word,
  output logic                  o_word_valid,
  input  logic                  i_credit
);
  import siggen_pkg::*;

  siggen_ctrl_t               ctrl;
  sample_t                    sine_sample;
  logic                       sine_valid;
  logic                       sine_ready;
  sample_t                    sel_sample;
  logic                       sel_valid;
  logic                       sel_ready;
  sample_t                    fifo_sample;
  logic                       fifo_valid;
  logic                       fifo_ready;
  out_word_t                  pkt_word;
  logic                       pkt_valid;
  logic                       pkt_ready;
  logic                       out_valid;
  logic                       out_ready;
  logic [SIGGEN_CREDIT_W-1:0] credit_cnt;

  siggen_setting_regs setting_regs_i (
    .i_ce_clk (i_ce_clk),
    .i_arst_n (i_arst_n),
    .i_set    (i_set),
    .o_ctrl   (ctrl)
  );

  siggen_sine_source sine_source_i (
    .i_ce_clk (i_ce_clk),
    .i_arst_n (i_arst_n),
    .i_freq   (ctrl.freq),
    .o_sample (sine_sample),
    .o_valid  (sine_valid),
    .i_ready  (sine_ready)
  );

  siggen_source_select source_select_i (
    .i_ctrl       (ctrl),
    .i_sine       (sine_sample),
    .i_sine_valid (sine_valid),
    .o_sine_ready (sine_ready),
    .o_sample     (sel_sample),
    .o_valid      (sel_valid),
    .i_ready      (sel_ready)
  );

  siggen_fifo #(
    .payload_t (sample_t),
    .DEPTH     (SIGGEN_SAMPLE_FIFO_DEPTH)
  ) sample_fifo_i (
    .i_ce_clk (i_ce_clk),
    .i_arst_n (i_arst_n),
    .i_data   (sel_sample),
    .i_valid  (sel_valid),
    .o_ready  (sel_ready),
    .o_data   (fifo_sample),
    .o_valid  (fifo_valid),
    .i_ready  (fifo_ready)
  );

  siggen_packetizer packetizer_i (
    .i_ce_clk     (i_ce_clk),
    .i_arst_n     (i_arst_n),
    .i_ctrl       (ctrl),
    .i_sample     (fifo_sample),
    .i_valid      (fifo_valid),
    .o_ready      (fifo_ready),
    .o_word       (pkt_word),
    .o_word_valid (pkt_valid),
    .i_word_ready (pkt_ready)
  );

  siggen_fifo #(
    .payload_t (out_word_t),
    .DEPTH     (SIGGEN_OUT_FIFO_DEPTH)
  ) out_fifo_i (
    .i_ce_clk (i_ce_clk),
    .i_arst_n (i_arst_n),
    .i_data   (pkt_word),
    .i_valid  (pkt_valid),
    .o_ready  (pkt_ready),
    .o_data   (o_word),
    .o_valid  (out_valid),
    .i_ready  (out_ready)
  );

  //////////////////////////////
  // Output credits
  //////////////////////////////
  assign out_ready    = (credit_cnt != '0);
  assign o_word_valid = out_valid & out_ready;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      credit_cnt <= SIGGEN_CREDIT_W'(SIGGEN_CREDITS);
    end else begin
      // Send and return in one cycle cancel out
      case ({o_word_valid, i_credit})
        2'b10: begin
          credit_cnt <= credit_cnt - 1'b1;
        end
        2'b01: begin
          if (credit_cnt != SIGGEN_CREDIT_W'(SIGGEN_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* siggen_packetizer.sv */
/* Packs samples two per 64-bit word behind a header word, last flag on the final word.
   A packet only starts once a first sample is waiting, so idle sources emit nothing. */

`default_nettype none

module siggen_packetizer (
  input  logic                     i_ce_clk,
  input  logic                     i_arst_n,
  input  siggen_pkg::siggen_ctrl_t i_ctrl,
  input  siggen_pkg::sample_t      i_sample,
  input  logic                     i_valid,
  output logic                     o_ready,
  output siggen_pkg::out_word_t    o_word,
  output logic                     o_word_valid,
  input  logic                     i_word_ready
);
  import siggen_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_BODY
  } state_t;

  state_t                  state_q;
  chdr_hdr_t               hdr_d;
  chdr_hdr_t               hdr_q;
  sample_t                 first_q;
  logic                    have_first_q;
  logic [SIGGEN_PKT_W-2:0] pair_cnt_q;
  logic [11:0]             seq_q;
  logic                    last_word;

  //////////////////////////////
  // Header build
  //////////////////////////////
  always_comb begin
    hdr_d.pkt_type = 2'b00;
    hdr_d.has_time = 1'b0;
    hdr_d.eob      = 1'b0;
    hdr_d.seqnum   = seq_q;
    // Bytes: one header word plus one word per sample pair
    hdr_d.length   = ({7'd0, i_ctrl.pkt_samples[SIGGEN_PKT_W-1:1]} + 16'd1) << 3;
    hdr_d.src_sid  = i_ctrl.src_sid;
    hdr_d.dst_sid  = i_ctrl.dst_sid;
  end

  assign last_word = (pair_cnt_q == (SIGGEN_PKT_W-1)'(1));

  //////////////////////////////
  // Output mux
  //////////////////////////////
  always_comb begin
    o_word.data  = {first_q, i_sample};
    o_word.last  = last_word;
    o_word_valid = 1'b0;
    o_ready      = 1'b0;
    case (state_q)
      ST_HDR: begin
        o_word.data  = hdr_q;
        o_word.last  = 1'b0;
        o_word_valid = 1'b1;
      end
      ST_BODY: begin
        // First of a pair is taken into the hold register at once
        o_word_valid = have_first_q & i_valid;
        o_ready      = have_first_q ? i_word_ready : 1'b1;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////
  // FSM and counters
  //////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q      <= ST_IDLE;
      have_first_q <= 1'b0;
      pair_cnt_q   <= '0;
      seq_q        <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_valid) begin
            state_q    <= ST_HDR;
            pair_cnt_q <= i_ctrl.pkt_samples[SIGGEN_PKT_W-1:1];
            seq_q      <= seq_q + 1'b1;
          end
        end
        ST_HDR: begin
          if (i_word_ready) begin
            state_q <= ST_BODY;
          end
        end
        ST_BODY: begin
          if (i_valid && !have_first_q) begin
            have_first_q <= 1'b1;
          end else if (i_valid && i_word_ready) begin
            have_first_q <= 1'b0;
            pair_cnt_q   <= pair_cnt_q - 1'b1;
            if (last_word) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Header latched at packet start, seqnum before its increment
  always_ff @(posedge i_ce_clk) begin
    if (state_q == ST_IDLE) begin
      hdr_q <= hdr_d;
    end
    if ((state_q == ST_BODY) && i_valid && !have_first_q) begin
      first_q <= i_sample;
    end
  end

endmodule

`default_nettype wire

/* siggen_source_select.sv */
/* Constant source and waveform select, all combinational.
   Unknown waveform codes give no valid and never pull from the sine source. */

`default_nettype none

module siggen_source_select (
  input  siggen_pkg::siggen_ctrl_t i_ctrl,
  input  siggen_pkg::sample_t      i_sine,
  input  logic                     i_sine_valid,
  output logic                     o_sine_ready,
  output siggen_pkg::sample_t      o_sample,
  output logic                     o_valid,
  input  logic                     i_ready
);
  import siggen_pkg::*;

  logic    sel_sine;
  logic    sel_const;
  sample_t const_sample;
  logic    const_valid;

  assign sel_sine  = i_ctrl.enable & (i_ctrl.wave == SIGGEN_WAVE_SINE);
  assign sel_const = i_ctrl.enable & (i_ctrl.wave == SIGGEN_WAVE_CONST);

  // Constant source repeats the amplitude register on every transfer
  assign const_sample = i_ctrl.amplitude;
  assign const_valid  = sel_const;

  assign o_sample     = sel_sine ? i_sine : const_sample;
  assign o_valid      = (sel_sine & i_sine_valid) | const_valid;

  // Sine only sees ready while it is the chosen source
  assign o_sine_ready = sel_sine & i_ready;

endmodule

`default_nettype wire

/* siggen_fifo.sv */
/* Synchronous circular-buffer FIFO for any payload type.
   Full and empty come from the count, so DEPTH need not be a power of two. */

`default_nettype none

module siggen_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic     i_ce_clk,
  input  logic     i_arst_n,
  input  payload_t i_data,
  input  logic     i_valid,
  output logic     o_ready,
  output payload_t o_data,
  output logic     o_valid,
  input  logic     i_ready
);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_ready = (count != CNT_W'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];
  assign push    = i_valid & o_ready;
  assign pop     = o_valid & i_ready;

  always_ff @(posedge i_ce_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* siggen_sine_source.sv */
/* Sine sample source with a 32-bit phase accumulator and a 256-entry table.
   Phase only advances on an accepted sample, so stalls never skip a value. */

`default_nettype none

module siggen_sine_source (
  input  logic                i_ce_clk,
  input  logic                i_arst_n,
  input  logic [31:0]         i_freq,
  output siggen_pkg::sample_t o_sample,
  output logic                o_valid,
  input  logic                i_ready
);
  import siggen_pkg::*;

  sample_t     sine_rom [SIGGEN_TABLE_SIZE];
  logic [31:0] phase_q;
  logic [31:0] phase_d;
  logic        valid_q;
  sample_t     sample_q;
  logic        accept;

  //////////////////////////////
  // Table, fixed at elaboration
  //////////////////////////////
  for (genvar g = 0; g < SIGGEN_TABLE_SIZE; g++) begin : g_rom
    localparam sample_t ENTRY = sine_entry(SIGGEN_TABLE_BITS'(g));
    assign sine_rom[g] = ENTRY;
  end

  assign accept  = valid_q & i_ready;
  assign phase_d = accept ? phase_q + i_freq : phase_q;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      phase_q <= '0;
      valid_q <= 1'b0;
    end else begin
      phase_q <= phase_d;
      // Always has a sample ready once out of reset
      valid_q <= 1'b1;
    end
  end

  // Table index from the top phase bits of the next phase
  always_ff @(posedge i_ce_clk) begin
    sample_q <= sine_rom[phase_d[31 -: SIGGEN_TABLE_BITS]];
  end

  assign o_sample = sample_q;
  assign o_valid  = valid_q;

endmodule

`default_nettype wire

/* siggen_setting_regs.sv */
/* Control registers on the settings bus. Writes show up one cycle after the strobe.
   Odd, zero or oversize packet sizes are dropped and the old value stays. */

`default_nettype none

module siggen_setting_regs (
  input  logic                     i_ce_clk,
  input  logic                     i_arst_n,
  input  siggen_pkg::set_bus_t     i_set,
  output siggen_pkg::siggen_ctrl_t o_ctrl
);
  import siggen_pkg::*;

  siggen_ctrl_t ctrl_q;
  logic         pkt_ok;

  // Packet size must be even and within 2..512
  assign pkt_ok = (i_set.data[0] == 1'b0) &&
                  (i_set.data != 32'd0) &&
                  (i_set.data <= 32'(SIGGEN_MAX_PKT_SAMPLES));

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ctrl_q             <= '0;
      ctrl_q.pkt_samples <= SIGGEN_PKT_W'(SIGGEN_DEFAULT_PKT_SAMPLES);
    end else if (i_set.stb) begin
      case (i_set.addr)
        SIGGEN_SR_FREQ: begin
          ctrl_q.freq <= i_set.data;
        end
        SIGGEN_SR_ENABLE: begin
          ctrl_q.enable <= i_set.data[0];
        end
        SIGGEN_SR_AMPLITUDE: begin
          ctrl_q.amplitude <= sample_t'(i_set.data);
        end
        SIGGEN_SR_PKT_SIZE: begin
          if (pkt_ok) begin
            ctrl_q.pkt_samples <= i_set.data[SIGGEN_PKT_W-1:0];
          end
        end
        SIGGEN_SR_WAVEFORM: begin
          ctrl_q.wave <= i_set.data[SIGGEN_WAVE_W-1:0];
        end
        SIGGEN_SR_SID: begin
          // Source in the upper half, destination in the lower
          ctrl_q.src_sid <= i_set.data[31:16];
          ctrl_q.dst_sid <= i_set.data[15:0];
        end
        default: begin
        end
      endcase
    end
  end

  assign o_ctrl = ctrl_q;

endmodule

`default_nettype wire

/* siggen_pkg.sv */
/* Shared constants, register map and types for the signal generator.
   sine_entry uses real math and only fills tables at elaboration time. */

`default_nettype none

package siggen_pkg;

  //////////////////////////////
  // Settings bus register map
  //////////////////////////////
  localparam int unsigned SIGGEN_SR_AWIDTH = 8;

  localparam logic [SIGGEN_SR_AWIDTH-1:0] SIGGEN_SR_FREQ      = 8'd128;
  localparam logic [SIGGEN_SR_AWIDTH-1:0] SIGGEN_SR_ENABLE    = 8'd132;
  localparam logic [SIGGEN_SR_AWIDTH-1:0] SIGGEN_SR_AMPLITUDE = 8'd138;
  localparam logic [SIGGEN_SR_AWIDTH-1:0] SIGGEN_SR_PKT_SIZE  = 8'd140;
  localparam logic [SIGGEN_SR_AWIDTH-1:0] SIGGEN_SR_WAVEFORM  = 8'd142;
  localparam logic [SIGGEN_SR_AWIDTH-1:0] SIGGEN_SR_SID       = 8'd144;

  // Waveform codes, anything else produces no samples
  localparam int unsigned SIGGEN_WAVE_W = 3;
  localparam logic [SIGGEN_WAVE_W-1:0] SIGGEN_WAVE_CONST = 3'd0;
  localparam logic [SIGGEN_WAVE_W-1:0] SIGGEN_WAVE_SINE  = 3'd1;

  //////////////////////////////
  // Sizes
  //////////////////////////////
  localparam int unsigned SIGGEN_TABLE_BITS          = 8;
  localparam int unsigned SIGGEN_TABLE_SIZE          = 2 ** SIGGEN_TABLE_BITS;
  localparam int unsigned SIGGEN_CREDITS             = 8;
  localparam int unsigned SIGGEN_CREDIT_W            = $clog2(SIGGEN_CREDITS + 1);
  localparam int unsigned SIGGEN_SAMPLE_FIFO_DEPTH   = 4;
  localparam int unsigned SIGGEN_OUT_FIFO_DEPTH      = 4;
  localparam int unsigned SIGGEN_MAX_PKT_SAMPLES     = 512;
  localparam int unsigned SIGGEN_DEFAULT_PKT_SAMPLES = 64;
  localparam int unsigned SIGGEN_PKT_W               = 10;

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef struct packed {
    logic                        stb;
    logic [SIGGEN_SR_AWIDTH-1:0] addr;
    logic [31:0]                 data;
  } set_bus_t;

  // I in the upper half, as on the 32-bit sample bus
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } sample_t;

  typedef struct packed {
    logic [31:0]              freq;
    sample_t                  amplitude;
    logic [SIGGEN_WAVE_W-1:0] wave;
    logic                     enable;
    logic [SIGGEN_PKT_W-1:0]  pkt_samples;
    logic [15:0]              src_sid;
    logic [15:0]              dst_sid;
  } siggen_ctrl_t;

  // Compressed VITA style header, no timestamp word follows
  typedef struct packed {
    logic [1:0]  pkt_type;
    logic        has_time;
    logic        eob;
    logic [11:0] seqnum;
    logic [15:0] length;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } chdr_hdr_t;

  typedef struct packed {
    logic [63:0] data;
    logic        last;
  } out_word_t;

  // Cosine on I, sine on Q, full scale 32767
  function automatic sample_t sine_entry(input logic [SIGGEN_TABLE_BITS-1:0] idx);
    real     ang;
    sample_t s;
    ang = 2.0 * 3.14159265358979323846 * idx / real'(SIGGEN_TABLE_SIZE);
    s.i = 16'(int'(32767.0 * $cos(ang)));
    s.q = 16'(int'(32767.0 * $sin(ang)));
    return s;
  endfunction

endpackage

`default_nettype wire
